// ==== project.f ====
+incdir+include
source/gl_pkg.sv
source/gl_mem_arbiter.sv
source/gl_fetch.sv
source/gl_decode.sv
source/gl_matrix_stack.sv
source/gl_transform.sv
source/gl_core.sv
verification/gl_tb_mem.sv
verification/gl_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the geometry front end testbench

VERILATOR ?= verilator
TOP       ?= gl_core_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/gl_core_tb.sv ====
`timescale 1ns/10ps
`include "gl_defs.svh"

module gl_core_tb
    import gl_pkg::*;
();

    localparam int     CLK_PERIOD      = 40;
    localparam int     N_INST          = 61;  // 60 commands plus the end marker
    localparam int     CODE_WORDS      = 64;  // operand blocks go after the code
    localparam int     CYCLES_PER_INST = 200;
    localparam fixed_t ONE             = 32'sh0001_0000; // 1.0 in Q16.16

    logic   clk1 = 1'b0;
    logic   reset;
    addr_t  mem_araddr;
    logic   mem_arvalid;
    logic   mem_arready;
    word_t  mem_rdata;
    logic   mem_rvalid;
    logic   mem_rready;
    fixed_t vertex_x;
    fixed_t vertex_y;
    fixed_t vertex_z;
    logic   vertex_valid;
    logic   vertex_ready;
    logic   done;

    int     seed;
    int     code_ptr;                       // next instruction word
    int     data_ptr;                       // next operand word
    // reference model state
    fixed_t cur_mat   [16];
    fixed_t saved_mat [`GL_STACK_DEPTH][16];
    int     depth;
    fixed_t vp        [4];                  // x y w h
    fixed_t exp_x [$];
    fixed_t exp_y [$];
    fixed_t exp_z [$];
    // output monitor
    int     ready_run;                      // cycles left in this ready stretch
    logic   last_valid;
    logic   last_ready;
    fixed_t last_x;
    fixed_t last_y;
    fixed_t last_z;

    initial
    begin
        forever #(CLK_PERIOD/2) clk1 = ~clk1;
    end

    gl_core UUT (
        .clk1         (clk1),
        .reset        (reset),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rdata    (mem_rdata),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready),
        .vertex_x     (vertex_x),
        .vertex_y     (vertex_y),
        .vertex_z     (vertex_z),
        .vertex_valid (vertex_valid),
        .vertex_ready (vertex_ready),
        .done         (done)
    );

    gl_tb_mem u_mem (
        .clk1    (clk1),
        .reset   (reset),
        .araddr  (mem_araddr),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .rdata   (mem_rdata),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready)
    );

    ////////////////////
    // error exits
    ////////////////////

    task automatic report_mismatch(input string name, input fixed_t got, input fixed_t want);
        $display("MISMATCH time=%0t %s got %h expected %h", $time, name, got, want);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR time=%0t %s", $time, why);
        $display("Checks failed");
        $fatal(1);
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // 64 bit product, arithmetic shift by the fraction bits, low word kept
    function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return fixed_t'(p >>> `GL_FRAC_BITS);
    endfunction

    task automatic model_vertex(input fixed_t v [16]);
        fixed_t clip [3];
        fixed_t sum;
        longint px;
        longint py;
        int     r;
        int     k;
        for (r = 0; r < 3; r++)           // w row not needed, no divide
        begin
            sum = '0;
            for (k = 0; k < 4; k++)
                sum = sum + fixed_mul(cur_mat[4*r + k], v[k]); // wraps at 32 bits
            clip[r] = sum;
        end
        px = (longint'(clip[0]) + longint'(ONE)) * longint'(vp[2]);
        py = (longint'(clip[1]) + longint'(ONE)) * longint'(vp[3]);
        exp_x.push_back(vp[0] + fixed_t'(px >>> (`GL_FRAC_BITS + 1)));
        exp_y.push_back(vp[1] + fixed_t'(py >>> (`GL_FRAC_BITS + 1)));
        exp_z.push_back(clip[2]);
    endtask

    task automatic model_apply(input opcode_t op, input fixed_t vals [16]);
        int i;
        case (op)
            OP_LOAD_MATRIX:
                for (i = 0; i < 16; i++)
                    cur_mat[i] = vals[i];
            OP_LOAD_IDENTITY:
                for (i = 0; i < 16; i++)
                    cur_mat[i] = (i % 5 == 0) ? ONE : '0; // diagonal 0 5 10 15
            OP_PUSH:
                if (depth < `GL_STACK_DEPTH) // full, dropped
                begin
                    saved_mat[depth] = cur_mat;
                    depth++;
                end
            OP_POP:
                if (depth > 0)               // empty, dropped
                begin
                    depth--;
                    cur_mat = saved_mat[depth];
                end
            OP_VIEWPORT:
                for (i = 0; i < 4; i++)
                    vp[i] = vals[i];
            OP_VERTEX:
                model_vertex(vals);
            default: ;                       // nop, end
        endcase
    endtask

    ////////////////////
    // program generator
    ////////////////////

    function automatic fixed_t rand_signed(input int limit);
        return fixed_t'($random(seed) % limit); // open range -limit..limit
    endfunction

    function automatic fixed_t rand_span(input int limit);
        return fixed_t'($unsigned($random(seed)) % limit); // 0..limit-1
    endfunction

    // vertices most of the time
    function automatic opcode_t pick_opcode();
        int r;
        r = $unsigned($random(seed)) % 20;
        if (r < 8)
            return OP_VERTEX;
        else if (r < 10)
            return OP_PUSH;
        else if (r < 12)
            return OP_POP;
        else if (r < 13)
            return OP_LOAD_IDENTITY;
        else if (r < 15)
            return OP_LOAD_MATRIX;
        else if (r < 17)
            return OP_VIEWPORT;
        else
            return OP_NOP;
    endfunction

    // writes one instruction and its operands, then steps the model
    task automatic emit(input opcode_t op);
        fixed_t vals [16];
        int     n;
        int     i;
        case (op)
            OP_LOAD_MATRIX:         n = 16;
            OP_VIEWPORT, OP_VERTEX: n = 4;
            default:                n = 0;
        endcase
        for (i = 0; i < 16; i++)
            vals[i] = '0;
        for (i = 0; i < n; i++)
        begin
            if (op == OP_LOAD_MATRIX)
                vals[i] = rand_signed(4 <<< `GL_FRAC_BITS);            // +-4.0
            else if (op == OP_VERTEX)
                vals[i] = (i == 3) ? ONE : rand_signed(2 <<< `GL_FRAC_BITS);
            else if (i < 2)
                vals[i] = rand_span(640 <<< `GL_FRAC_BITS);            // origin
            else
                vals[i] = ONE + rand_span(1024 <<< `GL_FRAC_BITS);     // size
            u_mem.mem[data_ptr + i] = word_t'(vals[i]);
        end
        u_mem.mem[code_ptr] = {1'b0, imm_t'(data_ptr), op}; // type bit left 0
        code_ptr++;
        data_ptr += n;
        model_apply(op, vals);
    endtask

    task automatic build_program();
        int i;
        for (i = 0; i < `GL_MEM_WORDS; i++)
            u_mem.mem[i] = 32'hBAD0_0000 | word_t'(i); // unused words
        for (i = 0; i < 16; i++)
            cur_mat[i] = (i % 5 == 0) ? ONE : '0;    // identity after reset
        depth          = 0;
        code_ptr       = 0;
        data_ptr       = CODE_WORDS;
        emit(OP_VIEWPORT);  // vp regs have no reset value
        emit(OP_VERTEX);    // identity
        emit(OP_LOAD_MATRIX);
        emit(OP_VERTEX);
        emit(OP_PUSH);
        emit(OP_LOAD_IDENTITY);
        emit(OP_VERTEX);
        emit(OP_POP);
        emit(OP_VERTEX);    // loaded matrix back
        // fifth push finds the stack full
        for (i = 0; i < 5; i++)
        begin
            emit(OP_PUSH);
            emit(OP_LOAD_MATRIX);
        end
        emit(OP_VERTEX);
        // last two pops find it empty
        for (i = 0; i < 6; i++)
        begin
            emit(OP_POP);
            emit(OP_VERTEX);
        end
        emit(OP_VIEWPORT);
        emit(OP_VERTEX);
        while (code_ptr < N_INST - 1)
            emit(pick_opcode());
        emit(OP_END);
    endtask

    ////////////////////
    // ready driver and output checks
    ////////////////////

    // ready chosen first, then a beat with valid high is taken on the next rising edge
    always @(negedge clk1)
    begin
        if (ready_run == 0)
        begin
            vertex_ready = ($random(seed) & 3) != 0; // low about a quarter of the time
            ready_run    = 1 + ($random(seed) & 7);
        end
        ready_run--;

        if (last_valid && !last_ready)   // waiting output must not move
        begin
            assert (vertex_valid)
            else abort_run("vertex_valid dropped before vertex_ready");
            assert (vertex_x == last_x)
            else report_mismatch("vertex_x held", vertex_x, last_x);
            assert (vertex_y == last_y)
            else report_mismatch("vertex_y held", vertex_y, last_y);
            assert (vertex_z == last_z)
            else report_mismatch("vertex_z held", vertex_z, last_z);
        end
        if (vertex_valid)
        begin
            assert (exp_x.size() != 0)
            else abort_run("vertex_valid with no vertex left in the expected queue");
        end
        if (vertex_valid && vertex_ready)
        begin
            assert (vertex_x == exp_x[0])
            else report_mismatch("vertex_x", vertex_x, exp_x[0]);
            assert (vertex_y == exp_y[0])
            else report_mismatch("vertex_y", vertex_y, exp_y[0]);
            assert (vertex_z == exp_z[0])
            else report_mismatch("vertex_z", vertex_z, exp_z[0]);
            void'(exp_x.pop_front());
            void'(exp_y.pop_front());
            void'(exp_z.pop_front());
        end
        last_valid = vertex_valid;
        last_ready = vertex_ready;
        last_x     = vertex_x;
        last_y     = vertex_y;
        last_z     = vertex_z;
    end

    ////////////////////
    // run control
    ////////////////////

    initial
    begin
        seed         = 3;
        reset        = 1'b1;
        vertex_ready = 1'b0;
        ready_run    = 0;
        last_valid   = 1'b0;
        last_ready   = 1'b0;
        build_program();
        repeat (2) @(negedge clk1);
        // port outputs cleared while reset is still high
        assert (mem_arvalid === 1'b0 && vertex_valid === 1'b0 && done === 1'b0)
        else abort_run("mem_arvalid, vertex_valid or done not cleared by reset");
        reset = 1'b0;
        while (done !== 1'b1)
            @(negedge clk1);
        // done can beat the last vertices out under back-pressure
        while (exp_x.size() != 0)
            @(negedge clk1);
        repeat (20) @(negedge clk1); // no stray vertex afterwards
        if (done === 1'b1 && !vertex_valid)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            abort_run("end state wrong, done low or output still valid");
        end
    end

    // bound from the program length
    initial
    begin
        #(N_INST * CYCLES_PER_INST * CLK_PERIOD);
        abort_run("timeout before done and the last vertex");
    end

endmodule

// ==== verification/gl_tb_mem.sv ====
`timescale 1ns/10ps
`include "gl_defs.svh"

module gl_tb_mem
    import gl_pkg::*;
(
    input  logic  clk1,
    input  logic  reset,
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    output word_t rdata,
    output logic  rvalid,
    input  logic  rready
);

    localparam int IDX_W = $clog2(`GL_MEM_WORDS);

    word_t mem [`GL_MEM_WORDS]; // loaded by the testbench before reset release
    int    seed;                // own stream, separate from the program generator
    addr_t addr_q;              // address of the read in progress

    ////////////////////
    // read slave
    ////////////////////

    // all outputs change on the falling edge, one read at a time
    initial
    begin
        seed    = 3;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever
        begin
            @(negedge clk1);
            if (!reset && arvalid)
            begin
                repeat ($random(seed) & 3) @(negedge clk1); // 0..3 wait cycles on AR
                addr_q  = araddr;  // master holds it until arready
                arready = 1'b1;
                @(negedge clk1);   // AR beat on the rising edge just passed
                arready = 1'b0;
                repeat ($random(seed) & 3) @(negedge clk1); // 0..3 wait cycles on R
                rdata  = mem[addr_q[IDX_W-1:0]];
                rvalid = 1'b1;
                // rready seen here holds through the next rising edge
                while (!rready)
                    @(negedge clk1);
                @(negedge clk1);   // R beat done
                rvalid = 1'b0;
            end
        end
    end

endmodule

// ==== source/gl_core.sv ====
`timescale 1ns/10ps

module gl_core
    import gl_pkg::*;
(
    input  logic   clk1,
    input  logic   reset,
    // AXI4-Lite read port
    output addr_t  mem_araddr,
    output logic   mem_arvalid,
    input  logic   mem_arready,
    input  word_t  mem_rdata,
    input  logic   mem_rvalid,
    output logic   mem_rready,
    // finished vertices
    output fixed_t vertex_x,
    output fixed_t vertex_y,
    output fixed_t vertex_z,
    output logic   vertex_valid,
    input  logic   vertex_ready,
    output logic   done
);

    // fetch master
    addr_t      fetch_araddr;
    logic       fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    word_t      fetch_rdata;
    // decode master
    addr_t      data_araddr;
    logic       data_arvalid, data_arready, data_rvalid, data_rready;
    word_t      data_rdata;
    // fetch to decode
    word_t      inst;
    logic       inst_valid, inst_take;
    // decode to stack and transform
    logic       push_en, pop_en, identity_en, elem_write_en;
    logic [3:0] elem_index;
    fixed_t     elem_data;
    matrix_t    current;
    logic       xf_start, xf_busy;
    fixed_t     vp_x, vp_y, vp_w, vp_h;
    fixed_t     vert_x, vert_y, vert_z, vert_w;

    ////////////////////
    // front end
    ////////////////////

    gl_fetch u_fetch (.*);

    gl_decode u_decode (.*);

    gl_mem_arbiter u_arbiter (.*);

    ////////////////////
    // geometry
    ////////////////////

    gl_matrix_stack u_stack (
        .clk1          (clk1),
        .reset         (reset),
        .push_en       (push_en),
        .pop_en        (pop_en),
        .identity_en   (identity_en),
        .elem_write_en (elem_write_en),
        .elem_index    (elem_index),
        .elem_data     (elem_data),
        .current       (current)
    );

    gl_transform u_xform (.*); // vertex port goes straight to the top

endmodule

// ==== source/gl_transform.sv ====
`timescale 1ns/10ps
`include "gl_defs.svh"

module gl_transform
    import gl_pkg::*;
(
    input  logic    clk1,
    input  logic    reset,
    input  logic    xf_start,
    input  matrix_t current,
    input  fixed_t  vp_x,
    input  fixed_t  vp_y,
    input  fixed_t  vp_w,
    input  fixed_t  vp_h,
    input  fixed_t  vert_x,
    input  fixed_t  vert_y,
    input  fixed_t  vert_z,
    input  fixed_t  vert_w,
    output logic    xf_busy,
    output fixed_t  vertex_x,
    output fixed_t  vertex_y,
    output fixed_t  vertex_z,
    output logic    vertex_valid,
    input  logic    vertex_ready
);

    xform_state_t       state;
    logic [1:0]         row;
    matrix_t            m_q;         // matrix snapshot
    fixed_t             v_q    [4];  // x y z w
    fixed_t             vp_q   [4];  // x y w h
    fixed_t             clip_q [3];  // cx cy cz, w row unused
    fixed_t             row_sum;
    logic signed [63:0] px, py;      // mapping products
    logic               out_free;

    // 64 bit product, >>> frac, low word kept
    function automatic fixed_t fx_mul(input fixed_t a, input fixed_t b);
        logic signed [63:0] p;
        p = a * b;
        return p[`GL_FRAC_BITS +: `GL_DATA_W];
    endfunction

    // four multipliers, reused for every row
    always_comb
    begin
        row_sum = '0;
        for (int k = 0; k < 4; k++)
            row_sum = row_sum + fx_mul(m_q[(4*row + k)*`GL_DATA_W +: `GL_DATA_W], v_q[k]);
    end

    // screen = vp + ((c + 1.0) * size) >>> 17
    assign px       = (clip_q[0] + FX_ONE) * vp_q[2];
    assign py       = (clip_q[1] + FX_ONE) * vp_q[3];
    assign out_free = !vertex_valid || vertex_ready;
    assign xf_busy  = (state != XF_IDLE);

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state        <= XF_IDLE;
            row          <= '0;
            vertex_valid <= 1'b0;
        end
        else
        begin
            if (vertex_valid && vertex_ready)
                vertex_valid <= 1'b0;
            case (state)
                XF_IDLE:
                    if (xf_start)
                    begin
                        state <= XF_ROW;
                        row   <= '0;
                    end
                XF_ROW:
                begin
                    row <= row + 1'b1;
                    if (row == 2'd3)
                        state <= XF_MAP;
                end
                default:
                    if (out_free)
                    begin
                        vertex_valid <= 1'b1; // 5 cycles after start at best
                        state        <= XF_IDLE;
                    end
            endcase
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (state == XF_IDLE && xf_start)
        begin
            m_q  <= current;
            v_q  <= '{vert_x, vert_y, vert_z, vert_w};
            vp_q <= '{vp_x, vp_y, vp_w, vp_h};
        end
        if (state == XF_ROW && row != 2'd3)
            clip_q[row] <= row_sum;
        if (state == XF_MAP && out_free)
        begin
            vertex_x <= vp_q[0] + fixed_t'(px >>> (`GL_FRAC_BITS + 1));
            vertex_y <= vp_q[1] + fixed_t'(py >>> (`GL_FRAC_BITS + 1));
            vertex_z <= clip_q[2];
        end
    end

    a_out_hold: assert property (@(posedge clk1) disable iff (reset)
        vertex_valid && !vertex_ready |=> vertex_valid && $stable(vertex_x)
            && $stable(vertex_y) && $stable(vertex_z));

endmodule

// ==== source/gl_matrix_stack.sv ====
`timescale 1ns/10ps
`include "gl_defs.svh"

module gl_matrix_stack
    import gl_pkg::*;
(
    input  logic       clk1,
    input  logic       reset,
    input  logic       push_en,
    input  logic       pop_en,
    input  logic       identity_en,
    input  logic       elem_write_en,
    input  logic [3:0] elem_index,
    input  fixed_t     elem_data,
    output matrix_t    current
);

    localparam int PTR_W = $clog2(`GL_STACK_DEPTH);

    matrix_t          saved [`GL_STACK_DEPTH];
    logic [PTR_W:0]   depth;   // saved matrices, 0 .. GL_STACK_DEPTH
    logic [PTR_W-1:0] top_idx; // newest saved entry
    matrix_t          ident;

    assign top_idx = PTR_W'(depth - 1'b1);

    // 1.0 on the diagonal, elements 0, 5, 10, 15
    always_comb
    begin
        ident = '0;
        for (int i = 0; i < 4; i++)
            ident[(5*i)*`GL_DATA_W +: `GL_DATA_W] = FX_ONE;
    end

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            current <= ident;
            depth   <= '0;
        end
        else
        begin
            if (push_en && depth < `GL_STACK_DEPTH)      // full stack ignores push
            begin
                saved[depth[PTR_W-1:0]] <= current;
                depth <= depth + 1'b1;
            end
            if (pop_en && depth != 0)                   // empty stack ignores pop
            begin
                current <= saved[top_idx];
                depth   <= depth - 1'b1;
            end
            if (identity_en)
                current <= ident;
            if (elem_write_en)
                current[elem_index*`GL_DATA_W +: `GL_DATA_W] <= elem_data;
        end
    end

    a_depth_max: assert property (@(posedge clk1) disable iff (reset)
        depth <= `GL_STACK_DEPTH);

endmodule

// ==== source/gl_decode.sv ====
`timescale 1ns/10ps

module gl_decode
    import gl_pkg::*;
(
    input  logic       clk1,
    input  logic       reset,
    input  word_t      inst,
    input  logic       inst_valid,
    output logic       inst_take,
    // operand read master
    output addr_t      data_araddr,
    output logic       data_arvalid,
    input  logic       data_arready,
    input  word_t      data_rdata,
    input  logic       data_rvalid,
    output logic       data_rready,
    // matrix stack
    output logic       push_en,
    output logic       pop_en,
    output logic       identity_en,
    output logic       elem_write_en,
    output logic [3:0] elem_index,
    output fixed_t     elem_data,
    // transform
    output logic       xf_start,
    input  logic       xf_busy,
    output fixed_t     vp_x,
    output fixed_t     vp_y,
    output fixed_t     vp_w,
    output fixed_t     vp_h,
    output fixed_t     vert_x,
    output fixed_t     vert_y,
    output fixed_t     vert_z,
    output fixed_t     vert_w,
    output logic       done
);

    decode_state_t state;
    opcode_t       inst_op;  // field split of the buffered word
    imm_t          inst_imm;
    opcode_t       op_q;     // instruction being executed
    addr_t         rd_addr;  // next operand word
    logic [3:0]    word_idx; // operand counter
    logic [3:0]    last_idx; // 15 for a matrix, 3 otherwise

    assign inst_op  = opcode_t'(inst[7:0]);
    assign inst_imm = inst[30:8]; // bit 31 reserved

    assign inst_take    = (state == DEC_IDLE) && inst_valid;
    assign data_araddr  = rd_addr;
    assign data_arvalid = (state == DEC_ADDR);
    assign data_rready  = (state == DEC_DATA);

    ////////////////////
    // command FSM
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state         <= DEC_IDLE;
            push_en       <= 1'b0;
            pop_en        <= 1'b0;
            identity_en   <= 1'b0;
            elem_write_en <= 1'b0;
            xf_start      <= 1'b0;
            done          <= 1'b0;
        end
        else
        begin
            push_en       <= 1'b0; // all single cycle strobes
            pop_en        <= 1'b0;
            identity_en   <= 1'b0;
            elem_write_en <= 1'b0;
            xf_start      <= 1'b0;
            case (state)
                DEC_IDLE:
                    if (inst_valid)
                    begin
                        case (inst_op)
                            OP_PUSH:          push_en     <= 1'b1;
                            OP_POP:           pop_en      <= 1'b1;
                            OP_LOAD_IDENTITY: identity_en <= 1'b1;
                            OP_LOAD_MATRIX, OP_VIEWPORT, OP_VERTEX:
                                state <= DEC_ADDR;
                            OP_END:
                            begin
                                done  <= 1'b1; // sticky
                                state <= DEC_DONE;
                            end
                            default: ; // NOP and unknown codes
                        endcase
                    end
                DEC_ADDR:
                    if (data_arready)
                        state <= DEC_DATA;
                DEC_DATA:
                    if (data_rvalid)
                    begin
                        elem_write_en <= (op_q == OP_LOAD_MATRIX);
                        if (word_idx != last_idx)
                            state <= DEC_ADDR;
                        else
                            state <= (op_q == OP_VERTEX) ? DEC_VERTEX : DEC_IDLE;
                    end
                DEC_VERTEX:
                    if (!xf_busy)
                    begin
                        xf_start <= 1'b1; // transform latches vertex next edge
                        state    <= DEC_IDLE;
                    end
                default: ; // DEC_DONE holds
            endcase
        end
    end

    ////////////////////
    // operand registers
    ////////////////////

    always_ff @(posedge clk1)
    begin
        if (inst_take)
        begin
            op_q     <= inst_op;
            rd_addr  <= addr_t'(inst_imm);
            word_idx <= '0;
            last_idx <= (inst_op == OP_LOAD_MATRIX) ? 4'd15 : 4'd3;
        end
        else if (data_rvalid && data_rready)
        begin
            rd_addr    <= rd_addr + 1'b1;
            word_idx   <= word_idx + 1'b1;
            elem_index <= word_idx; // row major element number
            elem_data  <= fixed_t'(data_rdata);
            if (op_q == OP_VIEWPORT)
            begin
                case (word_idx[1:0])
                    2'd0:    vp_x <= fixed_t'(data_rdata);
                    2'd1:    vp_y <= fixed_t'(data_rdata);
                    2'd2:    vp_w <= fixed_t'(data_rdata);
                    default: vp_h <= fixed_t'(data_rdata);
                endcase
            end
            else if (op_q == OP_VERTEX)
            begin
                case (word_idx[1:0])
                    2'd0:    vert_x <= fixed_t'(data_rdata);
                    2'd1:    vert_y <= fixed_t'(data_rdata);
                    2'd2:    vert_z <= fixed_t'(data_rdata);
                    default: vert_w <= fixed_t'(data_rdata);
                endcase
            end
        end
    end

    // transform must only go busy after a start it has seen
    a_start_idle: assert property (@(posedge clk1) disable iff (reset)
        xf_start |-> !xf_busy);

endmodule

// ==== source/gl_fetch.sv ====
`timescale 1ns/10ps

module gl_fetch
    import gl_pkg::*;
(
    input  logic  clk1,
    input  logic  reset,
    // read master
    output addr_t fetch_araddr,
    output logic  fetch_arvalid,
    input  logic  fetch_arready,
    input  word_t fetch_rdata,
    input  logic  fetch_rvalid,
    output logic  fetch_rready,
    // to decode
    output word_t inst,
    output logic  inst_valid,
    input  logic  inst_take
);

    addr_t pc;      // next word to read
    logic  rd_wait; // AR accepted, R not yet back
    logic  stopped; // OP_END went to decode

    assign fetch_araddr = pc;
    assign fetch_rready = rd_wait; // buffer is empty whenever a read is out

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            pc            <= '0;
            fetch_arvalid <= 1'b0;
            rd_wait       <= 1'b0;
            inst_valid    <= 1'b0;
            stopped       <= 1'b0;
        end
        else
        begin
            // address phase
            if (fetch_arvalid && fetch_arready)
            begin
                fetch_arvalid <= 1'b0;
                rd_wait       <= 1'b1;
                pc            <= pc + 1'b1;
            end
            else if (!fetch_arvalid && !rd_wait && !inst_valid && !stopped)
                fetch_arvalid <= 1'b1; // refill as soon as decode takes the word

            // data phase and buffer
            if (fetch_rvalid && fetch_rready)
            begin
                rd_wait    <= 1'b0;
                inst_valid <= 1'b1;
            end
            else if (inst_take)
            begin
                inst_valid <= 1'b0;
                if (opcode_t'(inst[7:0]) == OP_END)
                    stopped <= 1'b1; // nothing past the end
            end
        end
    end

    // one word buffer
    always_ff @(posedge clk1)
    begin
        if (fetch_rvalid && fetch_rready)
            inst <= fetch_rdata;
    end

endmodule

// ==== source/gl_mem_arbiter.sv ====
`timescale 1ns/10ps

module gl_mem_arbiter
    import gl_pkg::*;
(
    input  logic  clk1,
    input  logic  reset,
    // instruction fetch master
    input  addr_t fetch_araddr,
    input  logic  fetch_arvalid,
    output logic  fetch_arready,
    output word_t fetch_rdata,
    output logic  fetch_rvalid,
    input  logic  fetch_rready,
    // decode operand master
    input  addr_t data_araddr,
    input  logic  data_arvalid,
    output logic  data_arready,
    output word_t data_rdata,
    output logic  data_rvalid,
    input  logic  data_rready,
    // shared memory port
    output addr_t mem_araddr,
    output logic  mem_arvalid,
    input  logic  mem_arready,
    input  word_t mem_rdata,
    input  logic  mem_rvalid,
    output logic  mem_rready
);

    logic owner_valid; // a master holds the grant
    logic owner;       // 1 = data, 0 = fetch; also the last one served
    logic addr_sent;   // AR done, waiting on R
    logic pick;

    // round robin, the master not served last wins a tie
    assign pick = (fetch_arvalid && data_arvalid) ? ~owner : data_arvalid;

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            owner_valid <= 1'b0;
            owner       <= 1'b0;
            addr_sent   <= 1'b0;
        end
        else if (!owner_valid)
        begin
            if (fetch_arvalid || data_arvalid)
            begin
                owner_valid <= 1'b1;
                owner       <= pick;
            end
        end
        else if (!addr_sent)
        begin
            if (mem_arvalid && mem_arready)
                addr_sent <= 1'b1;
        end
        else if (mem_rvalid && mem_rready)
        begin
            owner_valid <= 1'b0; // read retired, rearbitrate
            addr_sent   <= 1'b0;
        end
    end

    ////////////////////
    // channel routing
    ////////////////////

    assign mem_araddr  = owner ? data_araddr : fetch_araddr;
    assign mem_arvalid = owner_valid && !addr_sent && (owner ? data_arvalid : fetch_arvalid);
    assign mem_rready  = addr_sent && (owner ? data_rready : fetch_rready);

    assign fetch_arready = owner_valid && !addr_sent && !owner && mem_arready;
    assign data_arready  = owner_valid && !addr_sent && owner && mem_arready;
    assign fetch_rvalid  = addr_sent && !owner && mem_rvalid;
    assign data_rvalid   = addr_sent && owner && mem_rvalid;
    assign fetch_rdata   = mem_rdata; // only the owner sees rvalid
    assign data_rdata    = mem_rdata;

    // grant is pinned from AR until the R beat
    a_grant_held: assert property (@(posedge clk1) disable iff (reset)
        addr_sent && !(mem_rvalid && mem_rready) |=> addr_sent && $stable(owner));

    // AXI rule on the shared port, covers both masters
    a_ar_stable: assert property (@(posedge clk1) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

endmodule

// ==== source/gl_pkg.sv ====
package gl_pkg;

`include "gl_defs.svh"

    typedef logic [`GL_DATA_W-1:0]        word_t;   // raw memory word
    typedef logic [`GL_ADDR_W-1:0]        addr_t;   // word address
    typedef logic signed [`GL_DATA_W-1:0] fixed_t;  // Q16.16
    typedef logic [22:0]                  imm_t;    // inst[30:8]
    typedef logic [16*`GL_DATA_W-1:0]     matrix_t; // row major, elem 0 in low bits

    // 1.0 in Q16.16, used by identity load and screen mapping
    localparam fixed_t FX_ONE = fixed_t'(1) <<< `GL_FRAC_BITS;

    // low byte of an instruction
    typedef enum logic [7:0] {
        OP_NOP           = 8'h00,
        OP_LOAD_MATRIX   = 8'h01, // 16 words at imm
        OP_LOAD_IDENTITY = 8'h02,
        OP_PUSH          = 8'h03,
        OP_POP           = 8'h04,
        OP_VIEWPORT      = 8'h05, // x, y, w, h at imm
        OP_VERTEX        = 8'h06, // x, y, z, w at imm
        OP_END           = 8'h07
    } opcode_t;

    typedef enum logic [2:0] {
        DEC_IDLE,   // wait for an instruction
        DEC_ADDR,   // operand read address phase
        DEC_DATA,   // operand read data phase
        DEC_VERTEX, // wait for transform to go idle
        DEC_DONE    // program finished
    } decode_state_t;

    typedef enum logic [1:0] {
        XF_IDLE,
        XF_ROW,     // one clip row per cycle
        XF_MAP      // viewport step, waits here on a full output reg
    } xform_state_t;

endpackage

// ==== include/gl_defs.svh ====
`ifndef GL_DEFS_SVH
`define GL_DEFS_SVH

////////////////////
// datapath widths
////////////////////

`define GL_DATA_W      32   // memory word
`define GL_ADDR_W      32   // word address

// fixed point format is Q16.16
`define GL_FRAC_BITS   16

////////////////////
// storage sizes
////////////////////

`define GL_STACK_DEPTH 4    // saved matrices, current one not counted
`define GL_MEM_WORDS   4096 // words in the command/data memory

`endif
